// File: source/mult_macros.svh
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// number of partial-product stages in the array
// it has to divide 64 evenly, so 2, 4 and 8 are the sensible choices
`define MULT_NUM_STAGE 8

// width of the destination tag that rides along with every multiply
`define MULT_TAG_WIDTH 6

`endif

// File: source/mult_pkg.sv
`include "mult_macros.svh"

package mult_pkg;

	// the five multiply flavours of the execution pipeline
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_mulw   = 3'd4
	} mult_op_e;

	// one request as it comes in from the issue side
	typedef struct packed {
		mult_op_e                   op;
		logic [`MULT_TAG_WIDTH-1:0] tag;
		logic [63:0]                mcand;
		logic [63:0]                mplier;
	} mult_req_t;

	// control that travels next to the data through every stage
	// negate tells the result stage to flip the sign of the magnitude
	typedef struct packed {
		mult_op_e                   op;
		logic [`MULT_TAG_WIDTH-1:0] tag;
		logic                       negate;
	} mult_ctrl_t;

	// running state handed from one partial-product stage to the next
	// the multiplicand is kept 128 bits wide since it moves left every stage
	typedef struct packed {
		logic [127:0] product;
		logic [127:0] mcand;
		logic [63:0]  mplier;
	} mult_flow_t;

	// what leaves the unit toward writeback
	typedef struct packed {
		logic [`MULT_TAG_WIDTH-1:0] tag;
		logic [63:0]                result;
	} mult_resp_t;

endpackage

// File: source/mult_operand_stage.sv
module mult_operand_stage (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  mult_pkg::mult_req_t request,
	output logic                done,
	output mult_pkg::mult_ctrl_t ctrl,
	output mult_pkg::mult_flow_t flow
);

	logic [63:0] mcand_ext;
	logic [63:0] mplier_ext;
	logic        mcand_signed;
	logic        mplier_signed;
	logic        mcand_neg;
	logic        mplier_neg;
	logic [63:0] mcand_mag;
	logic [63:0] mplier_mag;

	// word multiplies only look at the low halves, sign-extended
	// the upper operand bits are thrown away here
	always_comb begin
		if (request.op == mult_pkg::op_mulw) begin
			mcand_ext  = {{32{request.mcand[31]}}, request.mcand[31:0]};
			mplier_ext = {{32{request.mplier[31]}}, request.mplier[31:0]};
		end else begin
			mcand_ext  = request.mcand;
			mplier_ext = request.mplier;
		end
	end

	// plain mul is done unsigned because the low half does not depend on sign
	// mulhsu treats only the multiplicand as signed
	assign mcand_signed  = (request.op == mult_pkg::op_mulh) ||
	                       (request.op == mult_pkg::op_mulhsu) ||
	                       (request.op == mult_pkg::op_mulw);
	assign mplier_signed = (request.op == mult_pkg::op_mulh) ||
	                       (request.op == mult_pkg::op_mulw);

	assign mcand_neg  = mcand_signed & mcand_ext[63];
	assign mplier_neg = mplier_signed & mplier_ext[63];

	// absolute values, the most negative number maps to 2**63 which still
	// fits as an unsigned magnitude
	assign mcand_mag  = mcand_neg ? (~mcand_ext + 64'd1) : mcand_ext;
	assign mplier_mag = mplier_neg ? (~mplier_ext + 64'd1) : mplier_ext;

	// payload is loaded every cycle, valid or not
	always_ff @(posedge clock) begin
		ctrl.op      <= request.op;
		ctrl.tag     <= request.tag;
		ctrl.negate  <= mcand_neg ^ mplier_neg;
		flow.product <= 128'd0;
		flow.mcand   <= {64'd0, mcand_mag};
		flow.mplier  <= mplier_mag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// nothing may leave this stage in the cycle right after a reset
	done_low_after_reset: assert property (
		@(posedge clock) reset |=> !done
	);

endmodule

// File: source/mult_stage.sv
`include "mult_macros.svh"

module mult_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  mult_pkg::mult_ctrl_t ctrl_in,
	input  mult_pkg::mult_flow_t flow_in,
	output logic                 done,
	output mult_pkg::mult_ctrl_t ctrl_out,
	output mult_pkg::mult_flow_t flow_out
);

	// bits of the multiplier consumed per stage
	localparam int SLICE = 64 / `MULT_NUM_STAGE;

	logic [127:0] partial_product;
	logic [127:0] next_mcand;
	logic [63:0]  next_mplier;
	logic [127:0] prod_in_reg;
	logic [127:0] partial_prod_reg;
	logic [127:0] mcand_reg;
	logic [63:0]  mplier_reg;

	// one slice of the multiplier times the multiplicand shifted so far
	// the slice is zero-extended so the multiply is done at full width
	assign partial_product = {{(128-SLICE){1'b0}}, flow_in.mplier[SLICE-1:0]} * flow_in.mcand;

	// move on to the next slice
	assign next_mplier = flow_in.mplier >> SLICE;
	assign next_mcand  = flow_in.mcand << SLICE;

	always_ff @(posedge clock) begin
		prod_in_reg      <= flow_in.product;
		partial_prod_reg <= partial_product;
		mcand_reg        <= next_mcand;
		mplier_reg       <= next_mplier;
		ctrl_out         <= ctrl_in;
	end

	// the accumulate happens after the registers, so the adder sits in
	// front of the next stage's input flops
	assign flow_out.product = prod_in_reg + partial_prod_reg;
	assign flow_out.mcand   = mcand_reg;
	assign flow_out.mplier  = mplier_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// each stage is exactly one cycle of latency for the valid bit
	done_follows_start: assert property (
		@(posedge clock) !reset |=> (done == $past(start))
	);

endmodule

// File: source/mult_pipeline.sv
`include "mult_macros.svh"

module mult_pipeline (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  mult_pkg::mult_ctrl_t ctrl_in,
	input  mult_pkg::mult_flow_t flow_in,
	output logic                 done,
	output mult_pkg::mult_ctrl_t ctrl_out,
	output mult_pkg::mult_flow_t flow_out
);

	localparam int N = `MULT_NUM_STAGE;

	// element 0 is the array input, element N is the array output
	// everything in between connects stage i to stage i+1
	logic                 valid_chain [N+1];
	mult_pkg::mult_ctrl_t ctrl_chain  [N+1];
	mult_pkg::mult_flow_t flow_chain  [N+1];

	assign valid_chain[0] = start;
	assign ctrl_chain[0]  = ctrl_in;
	assign flow_chain[0]  = flow_in;

	genvar i;
	generate
		for (i = 0; i < N; i++) begin : g_stage
			// stage i retires multiplier bits [i*SLICE +: SLICE]
			mult_stage i_mult_stage (
				.clock    (clock),
				.reset    (reset),
				.start    (valid_chain[i]),
				.ctrl_in  (ctrl_chain[i]),
				.flow_in  (flow_chain[i]),
				.done     (valid_chain[i+1]),
				.ctrl_out (ctrl_chain[i+1]),
				.flow_out (flow_chain[i+1])
			);
		end
	endgenerate

	// after the last stage the whole multiplier has been consumed and
	// the product holds the full 128-bit magnitude
	assign done     = valid_chain[N];
	assign ctrl_out = ctrl_chain[N];
	assign flow_out = flow_chain[N];

endmodule

// File: source/mult_result_stage.sv
module mult_result_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  mult_pkg::mult_ctrl_t ctrl,
	input  logic [127:0]         product,
	output logic                 done,
	output mult_pkg::mult_resp_t response
);

	logic [127:0] signed_product;
	logic [63:0]  result;

	// restore the sign that the operand stage stripped off
	assign signed_product = ctrl.negate ? (~product + 128'd1) : product;

	// pick the half the operation asked for
	always_comb begin
		result = signed_product[63:0];
		case (ctrl.op)
			mult_pkg::op_mul: begin
				result = signed_product[63:0];
			end
			mult_pkg::op_mulh,
			mult_pkg::op_mulhsu,
			mult_pkg::op_mulhu: begin
				result = signed_product[127:64];
			end
			mult_pkg::op_mulw: begin
				// bit 31 of the 32-bit result is copied into the upper word
				result = {{32{signed_product[31]}}, signed_product[31:0]};
			end
			default: begin
				// unused encodings just fall back to the low half
				result = signed_product[63:0];
			end
		endcase
	end

	always_ff @(posedge clock) begin
		response.tag    <= ctrl.tag;
		response.result <= result;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// unsigned operations never arrive here with a sign flip requested
	unsigned_ops_not_negated: assert property (
		@(posedge clock) disable iff (reset)
		start && (ctrl.op == mult_pkg::op_mul || ctrl.op == mult_pkg::op_mulhu) |-> !ctrl.negate
	);

endmodule

// File: source/mult_unit.sv
`include "mult_macros.svh"

module mult_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  mult_pkg::mult_op_e         op,
	input  logic [`MULT_TAG_WIDTH-1:0] tag,
	input  logic [63:0]                mcand,
	input  logic [63:0]                mplier,
	output logic                       done,
	output logic [63:0]                result,
	output logic [`MULT_TAG_WIDTH-1:0] result_tag
);

	mult_pkg::mult_req_t  req;
	logic                 operand_done;
	mult_pkg::mult_ctrl_t operand_ctrl;
	mult_pkg::mult_flow_t operand_flow;
	logic                 pipe_done;
	mult_pkg::mult_ctrl_t pipe_ctrl;
	mult_pkg::mult_flow_t pipe_flow;
	mult_pkg::mult_resp_t resp;

	// bundle the loose request ports
	assign req.op     = op;
	assign req.tag    = tag;
	assign req.mcand  = mcand;
	assign req.mplier = mplier;

	// one cycle to form magnitudes
	mult_operand_stage i_mult_operand_stage (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.request (req),
		.done    (operand_done),
		.ctrl    (operand_ctrl),
		.flow    (operand_flow)
	);

	// MULT_NUM_STAGE cycles of partial products
	mult_pipeline i_mult_pipeline (
		.clock    (clock),
		.reset    (reset),
		.start    (operand_done),
		.ctrl_in  (operand_ctrl),
		.flow_in  (operand_flow),
		.done     (pipe_done),
		.ctrl_out (pipe_ctrl),
		.flow_out (pipe_flow)
	);

	// one more cycle for sign and half selection
	mult_result_stage i_mult_result_stage (
		.clock    (clock),
		.reset    (reset),
		.start    (pipe_done),
		.ctrl     (pipe_ctrl),
		.product  (pipe_flow.product),
		.done     (done),
		.response (resp)
	);

	assign result     = resp.result;
	assign result_tag = resp.tag;

endmodule

// File: verification/mult_clock_gen.sv
module mult_clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);

	// free-running clock, the first rising edge comes half a period in
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// reset drops on the rising edge that ends the last reset cycle
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: verification/mult_unit_tb.sv
`include "mult_macros.svh"

module mult_unit_tb;

	localparam int CLOCK_PERIOD = 8;
	// a start driven on edge j shows up as done right after edge j + LATENCY
	localparam int LATENCY      = `MULT_NUM_STAGE + 2;
	localparam int IDLE_CYCLES  = 20;
	localparam int DIRECTED_OPS = 5 * 4 * 4;
	localparam int BURST_OPS    = 300;
	localparam int GAP_OPS      = 200;
	localparam int MAX_GAP      = 5;
	localparam int MULW_OPS     = 100;
	localparam int SIGN_OPS     = 3 * 4 * 10;
	localparam int NUM_TESTS    = 5;
	// directed requests are sent one at a time, so each costs a full latency
	localparam int RUN_CYCLES   = 8 + IDLE_CYCLES + DIRECTED_OPS * (LATENCY + 2) + BURST_OPS +
		GAP_OPS * (MAX_GAP + 1) + MULW_OPS + SIGN_OPS + NUM_TESTS * (LATENCY + 6);

	// one outstanding request as the scoreboard sees it
	typedef struct packed {
		logic [`MULT_TAG_WIDTH-1:0] tag;
		logic [63:0]                result;
		logic [31:0]                due;
	} expect_t;

	logic                       clock;
	logic                       reset;
	logic                       start;
	mult_pkg::mult_op_e         op;
	logic [`MULT_TAG_WIDTH-1:0] tag;
	logic [63:0]                mcand;
	logic [63:0]                mplier;
	logic                       done;
	logic [63:0]                result;
	logic [`MULT_TAG_WIDTH-1:0] result_tag;

	logic [63:0]                rng_state = 64'd34400;
	logic [31:0]                cycle_count = 32'd0;
	logic [`MULT_TAG_WIDTH-1:0] next_tag = '0;
	expect_t                    pending [$];
	int                         error_count = 0;
	int                         pass_count = 0;
	int                         fail_count = 0;

	mult_clock_gen #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(3)) i_mult_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	mult_unit i_mult_unit (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.op         (op),
		.tag        (tag),
		.mcand      (mcand),
		.mplier     (mplier),
		.done       (done),
		.result     (result),
		.result_tag (result_tag)
	);

	// rising edge counter that stamps both due cycles and done cycles
	always @(posedge clock) begin
		cycle_count <= cycle_count + 32'd1;
	end

	// 64-bit xorshift generator
	function automatic logic [63:0] xorshift64();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	// operands lean on the corner values now and then
	function automatic logic [63:0] random_operand();
		logic [63:0] r;
		r = xorshift64();
		case (r[2:0])
			3'd0: return 64'd0;
			3'd1: return 64'd1;
			3'd2: return {64{1'b1}};
			3'd3: return {1'b1, 63'd0};
			default: return xorshift64();
		endcase
	endfunction

	function automatic mult_pkg::mult_op_e random_op();
		logic [63:0] r;
		r = xorshift64();
		return mult_pkg::mult_op_e'(3'(int'(r[7:0]) % 5));
	endfunction

	// the reference model works straight from the operation definitions
	// everything is done at 128 bits so no magnitude trick is involved
	function automatic logic [63:0] model_result(input mult_pkg::mult_op_e o,
			input logic [63:0] a, input logic [63:0] b);
		logic [127:0]        uprod;
		logic signed [127:0] sa;
		logic signed [127:0] sb;
		logic signed [127:0] sprod;
		logic signed [63:0]  wa;
		logic signed [63:0]  wb;
		logic signed [63:0]  wprod;
		logic [63:0]         res;
		uprod = {64'd0, a} * {64'd0, b};
		sa = $signed({{64{a[63]}}, a});
		sb = $signed({{64{b[63]}}, b});
		wa = $signed({{32{a[31]}}, a[31:0]});
		wb = $signed({{32{b[31]}}, b[31:0]});
		wprod = wa * wb;
		case (o)
			mult_pkg::op_mulh: begin
				sprod = sa * sb;
				res = sprod[127:64];
			end
			mult_pkg::op_mulhsu: begin
				// the multiplier is zero-extended so it is always a positive factor
				sprod = sa * $signed({64'd0, b});
				res = sprod[127:64];
			end
			mult_pkg::op_mulhu: res = uprod[127:64];
			mult_pkg::op_mulw: res = {{32{wprod[31]}}, wprod[31:0]};
			default: res = uprod[63:0];
		endcase
		return res;
	endfunction

	// drives one request on the next rising edge and records what must come back
	task automatic send(input mult_pkg::mult_op_e o, input logic [63:0] a,
			input logic [63:0] b);
		expect_t e;
		@(posedge clock);
		e.tag    = next_tag;
		e.result = model_result(o, a, b);
		e.due    = cycle_count + 32'(LATENCY + 1);
		pending.push_back(e);
		start  <= 1'b1;
		op     <= o;
		tag    <= next_tag;
		mcand  <= a;
		mplier <= b;
		next_tag = next_tag + `MULT_TAG_WIDTH'(1);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			start <= 1'b0;
		end
	endtask

	// waits for every outstanding response and gives up after one pipeline depth
	task automatic drain_pipeline();
		int waited;
		waited = 0;
		idle(1);
		while (pending.size() != 0 && waited < LATENCY + 4) begin
			idle(1);
			waited++;
		end
		if (pending.size() != 0) begin
			$display("ERROR at %0t: %0d requests never got a response", $time, pending.size());
			error_count += pending.size();
			pending.delete();
		end
	endtask

	task automatic finish_test(input string name, input int requests, input int errors_before);
		drain_pipeline();
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: %0d requests, passed", name, requests);
		end else begin
			fail_count++;
			$display("test %s: %0d requests, %0d errors", name, requests,
				error_count - errors_before);
		end
	endtask

	// every done pops the oldest request, which must land on its due cycle
	always @(negedge clock) begin
		expect_t e;
		if (!reset && done) begin
			if (pending.size() == 0) begin
				$display("ERROR at %0t: done pulse with no request outstanding", $time);
				error_count++;
			end else begin
				e = pending.pop_front();
				if (result !== e.result) begin
					$display("FAILED at %0t: result expected %h, got %h", $time, e.result, result);
					error_count++;
				end
				if (result_tag !== e.tag) begin
					$display("FAILED at %0t: result_tag expected %h, got %h", $time, e.tag,
						result_tag);
					error_count++;
				end
				if (cycle_count !== e.due) begin
					$display("FAILED at %0t: done cycle expected %0d, got %0d", $time, e.due,
						cycle_count);
					error_count++;
				end
			end
		end
	end

	// the watchdog is sized from the request counts of all tests with a margin of two
	initial begin
		#(2 * RUN_CYCLES * CLOCK_PERIOD);
		$display("ERROR at %0t: watchdog expired before the tests finished", $time);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [63:0] edge_values [4];
		logic [63:0] a;
		logic [63:0] b;
		int          errors_before;
		int          gap;
		start  = 1'b0;
		op     = mult_pkg::op_mul;
		tag    = '0;
		mcand  = 64'd0;
		mplier = 64'd0;
		edge_values[0] = 64'd0;
		edge_values[1] = 64'd1;
		edge_values[2] = {64{1'b1}};
		edge_values[3] = {1'b1, 63'd0};
		@(posedge clock);
		while (reset) @(posedge clock);

		// nothing may come out while no request has gone in
		errors_before = error_count;
		idle(IDLE_CYCLES);
		finish_test("reset_quiet", 0, errors_before);

		// every operation on the corner operands with one request at a time
		errors_before = error_count;
		for (int k = 0; k < 5; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					send(mult_pkg::mult_op_e'(3'(k)), edge_values[i], edge_values[j]);
					drain_pipeline();
				end
			end
		end
		finish_test("directed_edges", DIRECTED_OPS, errors_before);

		// a new request on every cycle keeps the whole array full
		errors_before = error_count;
		repeat (BURST_OPS) send(random_op(), random_operand(), random_operand());
		finish_test("back_to_back", BURST_OPS, errors_before);

		// idle gaps between requests let the due cycle check cover the done spacing
		errors_before = error_count;
		repeat (GAP_OPS) begin
			send(random_op(), random_operand(), random_operand());
			a = xorshift64();
			gap = int'(a[7:0]) % (MAX_GAP + 1);
			idle(gap);
		end
		finish_test("random_gaps", GAP_OPS, errors_before);

		// mulw with junk in the upper halves and then each high multiply per sign pair
		errors_before = error_count;
		repeat (MULW_OPS) begin
			a = random_operand();
			b = random_operand();
			a[63:32] = 32'(xorshift64() >> 32);
			b[63:32] = 32'(xorshift64() >> 32);
			send(mult_pkg::op_mulw, a, b);
		end
		for (int k = 1; k < 4; k++) begin
			for (int s = 0; s < 4; s++) begin
				repeat (10) begin
					a = xorshift64();
					b = xorshift64();
					a[63] = s[1];
					b[63] = s[0];
					send(mult_pkg::mult_op_e'(3'(k)), a, b);
				end
			end
		end
		finish_test("word_and_signs", MULW_OPS + SIGN_OPS, errors_before);

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+source
source/mult_pkg.sv
source/mult_operand_stage.sv
source/mult_stage.sv
source/mult_pipeline.sv
source/mult_result_stage.sv
source/mult_unit.sv
verification/mult_clock_gen.sv
verification/mult_unit_tb.sv

// File: Makefile
# Verilator build and run for the multiply unit testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= mult_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT  = Test completed successfully
BINARY     = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# the simulation log decides the outcome, grep fails the target when the pass line is missing
run: compile
	./$(BINARY) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
